// ==== logic/uart_pkg.sv ====
// Frame constants and packed structs shared by the UART RTL and its testbench; use by scoped name
package uart_pkg;

  // Frame is start bit, data bits LSB first, stop bit
  localparam int data_bits = 8;

  // Wide enough to index every data bit
  localparam int bit_index_w = 3;

  // Checker counter width, counters saturate at all ones
  localparam int count_w = 8;

  // Receiver output, pulses last one cycle
  typedef struct packed {
    logic [data_bits-1:0] data;
    logic                 valid;
    logic                 framing_err;
  } rx_frame_t;

  // Loopback checker results
  typedef struct packed {
    logic [count_w-1:0] frames;
    logic [count_w-1:0] errors;
  } check_status_t;

endpackage

// ==== logic/uart_tx.sv ====
// Bit-serial UART transmitter, one bit per clock; takes a byte on valid/ready and drives the line
`timescale 1ns/100ps

module uart_tx (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::data_bits-1:0] data,
  input  logic                           valid,
  output logic                           ready,
  output logic                           line
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_t;

  tx_state_t                        state;
  logic [uart_pkg::bit_index_w-1:0] bit_idx;
  logic [uart_pkg::data_bits-1:0]   shift;
  logic                             accept;

  assign accept = valid && ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      bit_idx <= '0;
      ready   <= 1'b1;
      line    <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          line <= 1'b1;
          if (accept) begin
            state <= st_start;
            ready <= 1'b0;
          end
        end
        st_start: begin
          line    <= 1'b0;
          bit_idx <= '0;
          state   <= st_data;
        end
        st_data: begin
          line    <= shift[0];
          bit_idx <= bit_idx + 1'b1;
          // Last data bit when the counter is all ones
          if (&bit_idx) begin
            state <= st_stop;
          end
        end
        st_stop: begin
          line  <= 1'b1;
          ready <= 1'b1;
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Byte is loaded on accept and drained LSB first
  always_ff @(posedge clk) begin
    if (accept) begin
      shift <= data;
    end else if (state == st_data) begin
      shift <= shift >> 1;
    end
  end

endmodule

// ==== logic/uart_rx.sv ====
// Bit-serial UART receiver, one sample per bit; outputs a byte with a valid or framing-error pulse
`timescale 1ns/100ps

module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                line,
  output uart_pkg::rx_frame_t frame
);

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t                        state;
  logic [uart_pkg::bit_index_w-1:0] bit_idx;
  logic [uart_pkg::data_bits-1:0]   shift;
  logic [uart_pkg::data_bits-1:0]   data_q;
  logic                             valid_q;
  logic                             err_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      bit_idx <= '0;
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      // Result pulses default low
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      case (state)
        st_idle: begin
          // A low sample is taken as the start bit
          if (!line) begin
            bit_idx <= '0;
            state   <= st_data;
          end
        end
        st_data: begin
          bit_idx <= bit_idx + 1'b1;
          if (&bit_idx) begin
            state <= st_stop;
          end
        end
        st_stop: begin
          valid_q <= line;
          err_q   <= !line;
          state   <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Samples enter at the top so bit 0 ends up in the LSB
  always_ff @(posedge clk) begin
    if (state == st_data) begin
      shift <= {line, shift[uart_pkg::data_bits-1:1]};
    end
    if (state == st_stop && line) begin
      data_q <= shift;
    end
  end

  // Data holds its last good byte between frames
  assign frame = '{data: data_q, valid: valid_q, framing_err: err_q};

endmodule

// ==== logic/loopback_checker.sv ====
// Loopback self-checker; queues sent bytes, matches them against received frames, counts errors
`timescale 1ns/100ps

module loopback_checker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           accept,
  input  logic [uart_pkg::data_bits-1:0] sent,
  input  uart_pkg::rx_frame_t            frame,
  input  logic                           enable,
  output uart_pkg::check_status_t        status
);

  logic [uart_pkg::data_bits-1:0] queue [2];
  logic [1:0]                     level;
  logic [1:0]                     level_after_pop;
  logic                           do_push;
  logic                           do_pop;
  logic                           pop_ok;
  logic                           push_ok;
  logic                           mismatch;
  logic [uart_pkg::count_w-1:0]   frames_q;
  logic [uart_pkg::count_w-1:0]   errors_q;

  assign do_push = enable && accept;
  assign do_pop  = enable && (frame.valid || frame.framing_err);

  assign pop_ok          = do_pop && (level != 2'd0);
  assign level_after_pop = level - {1'b0, pop_ok};
  // Full queue drops the push
  assign push_ok         = do_push && (level_after_pop != 2'd2);

  // Empty queue on a frame means an unexpected byte
  assign mismatch = frame.framing_err || (level == 2'd0) || (frame.data != queue[0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level    <= 2'd0;
      frames_q <= '0;
      errors_q <= '0;
    end else begin
      level <= level_after_pop + {1'b0, push_ok};
      if (do_pop) begin
        if (frames_q != '1) begin
          frames_q <= frames_q + 1'b1;
        end
        if (mismatch && errors_q != '1) begin
          errors_q <= errors_q + 1'b1;
        end
      end
    end
  end

  // Head is entry 0, pop shifts the queue down
  always_ff @(posedge clk) begin
    if (pop_ok) begin
      queue[0] <= queue[1];
    end
    if (push_ok) begin
      queue[level_after_pop[0]] <= sent;
    end
  end

  assign status = '{frames: frames_q, errors: errors_q};

endmodule

// ==== logic/uart_loopback.sv ====
// UART transmitter and receiver pair with internal loopback and a self-checker; the design top
`timescale 1ns/100ps

module uart_loopback (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           rx_in,
  input  logic [uart_pkg::data_bits-1:0] tx_data,
  input  logic                           tx_valid,
  input  logic                           loopback_enable,
  output logic                           tx_out,
  output logic                           tx_ready,
  output uart_pkg::rx_frame_t            rx_frame,
  output uart_pkg::check_status_t        status
);

  logic rx_line;
  logic tx_accept;

  // Receiver hears our own line in loopback
  assign rx_line   = loopback_enable ? tx_out : rx_in;
  assign tx_accept = tx_valid && tx_ready;

  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .data  (tx_data),
    .valid (tx_valid),
    .ready (tx_ready),
    .line  (tx_out)
  );

  uart_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .line  (rx_line),
    .frame (rx_frame)
  );

  loopback_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .accept (tx_accept),
    .sent   (tx_data),
    .frame  (rx_frame),
    .enable (loopback_enable),
    .status (status)
  );

endmodule

// ==== tb/uart_scoreboard.sv ====
// Testbench checker for the UART loopback top; models expected frames and counters, reports mismatches
`timescale 1ns/100ps

module uart_scoreboard (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::data_bits-1:0] tx_data,
  input  logic                           tx_valid,
  input  logic                           loopback_enable,
  input  logic                           tx_out,
  input  logic                           tx_ready,
  input  uart_pkg::rx_frame_t            rx_frame,
  input  uart_pkg::check_status_t        status,
  input  logic                           ext_start,
  input  logic [uart_pkg::data_bits-1:0] ext_byte,
  input  logic                           ext_bad,
  output int                             errors,
  output int                             pending
);

  int                             cycle;
  int                             acc_cycle;
  int                             pos;
  logic                           tx_active;
  logic                           reset_seen;
  logic [uart_pkg::data_bits-1:0] tx_byte;
  int                             frames_exp;
  logic                           hit;

  // Expected receiver results, ordered by due cycle
  int                             exp_due  [$];
  logic [uart_pkg::data_bits-1:0] exp_byte [$];
  logic                           exp_bad  [$];
  logic                           exp_lb   [$];

  initial begin
    errors  = 0;
    pending = 0;
  end

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL %s: expected %0h, actual %0h (cycle %0d)", name, expected, actual, cycle);
      errors = errors + 1;
    end
  endtask

  task automatic push_expect(input int due, input logic [uart_pkg::data_bits-1:0] b,
                             input logic bad, input logic lb);
    exp_due.push_back(due);
    exp_byte.push_back(b);
    exp_bad.push_back(bad);
    exp_lb.push_back(lb);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      cycle      = 0;
      tx_active  = 1'b0;
      reset_seen = 1'b0;
      frames_exp = 0;
      exp_due.delete();
      exp_byte.delete();
      exp_bad.delete();
      exp_lb.delete();
    end else begin
      cycle = cycle + 1;
      if (!reset_seen) begin
        check_value("reset tx_ready", 1, int'(tx_ready));
        check_value("reset tx_out", 1, int'(tx_out));
        check_value("reset rx valid", 0, int'(rx_frame.valid));
        check_value("reset rx framing_err", 0, int'(rx_frame.framing_err));
        check_value("reset frames", 0, int'(status.frames));
        check_value("reset errors", 0, int'(status.errors));
        reset_seen = 1'b1;
      end

      // Serial format and busy window after each accept
      if (tx_active) begin
        pos = cycle - acc_cycle;
        if (pos <= 10) begin
          check_value("tx_ready busy", 0, int'(tx_ready));
        end
        if (pos == 1) begin
          check_value("tx_out idle after accept", 1, int'(tx_out));
        end else if (pos == 2) begin
          check_value("tx_out start bit", 0, int'(tx_out));
        end else if (pos >= 3 && pos <= 10) begin
          check_value("tx_out data bit", int'(tx_byte >> (pos - 3)) & 1, int'(tx_out));
        end else if (pos >= 11) begin
          check_value("tx_out stop bit", 1, int'(tx_out));
          check_value("tx_ready after frame", 1, int'(tx_ready));
          tx_active = 1'b0;
        end
      end

      // Receiver results against the expected queue
      hit = (exp_due.size() > 0) && (exp_due[0] == cycle);
      if (rx_frame.valid || rx_frame.framing_err) begin
        if (!hit) begin
          $display("Receiver pulsed at cycle %0d with no frame expected", cycle);
          errors = errors + 1;
        end else begin
          check_value("rx framing_err", int'(exp_bad[0]), int'(rx_frame.framing_err));
          check_value("rx valid", int'(!exp_bad[0]), int'(rx_frame.valid));
          if (!exp_bad[0]) begin
            check_value("rx data", int'(exp_byte[0]), int'(rx_frame.data));
          end
        end
      end else if (hit) begin
        $display("Receiver gave no result at cycle %0d for an expected frame", cycle);
        errors = errors + 1;
      end

      // Counters lag the receiver pulse by one edge
      check_value("status frames", frames_exp, int'(status.frames));
      check_value("status errors", 0, int'(status.errors));

      if (hit) begin
        if (exp_lb[0] && frames_exp != 255) begin
          frames_exp = frames_exp + 1;
        end
        void'(exp_due.pop_front());
        void'(exp_byte.pop_front());
        void'(exp_bad.pop_front());
        void'(exp_lb.pop_front());
      end

      if (tx_valid && tx_ready) begin
        acc_cycle = cycle;
        tx_active = 1'b1;
        tx_byte   = tx_data;
        if (loopback_enable) begin
          push_expect(cycle + 12, tx_data, 1'b0, 1'b1);
        end
      end
      if (ext_start && !loopback_enable) begin
        push_expect(cycle + 10, ext_byte, ext_bad, 1'b0);
      end
    end
    pending = exp_due.size();
  end

endmodule

// ==== tb/uart_loopback_props.sv ====
// Concurrent assertions on the UART top handshake and pulse rules, attached to the top by bind
`timescale 1ns/100ps

module uart_loopback_props (
  input logic                clk,
  input logic                rst_n,
  input logic                tx_valid,
  input logic                tx_ready,
  input logic                tx_out,
  input uart_pkg::rx_frame_t rx_frame
);

  // Cycles since the last accept, zero when no frame is in flight
  logic [3:0] busy_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_cnt <= 4'd0;
    end else if (tx_valid && tx_ready) begin
      busy_cnt <= 4'd1;
    end else if (busy_cnt == 4'd11) begin
      busy_cnt <= 4'd0;
    end else if (busy_cnt != 4'd0) begin
      busy_cnt <= busy_cnt + 4'd1;
    end
  end

  a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_cnt != 4'd0 && busy_cnt <= 4'd10) |-> !tx_ready)
    else $error("tx_ready high within 10 cycles of an accept");

  a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_cnt == 4'd11) |-> tx_ready)
    else $error("tx_ready not back 11 cycles after an accept");

  a_pulse_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(rx_frame.valid && rx_frame.framing_err))
    else $error("valid and framing_err high together");

  a_valid_once: assert property (@(posedge clk) disable iff (!rst_n)
    rx_frame.valid |=> !rx_frame.valid)
    else $error("valid lasted more than one cycle");

  a_err_once: assert property (@(posedge clk) disable iff (!rst_n)
    rx_frame.framing_err |=> !rx_frame.framing_err)
    else $error("framing_err lasted more than one cycle");

  a_idle_line: assert property (@(posedge clk) disable iff (!rst_n)
    tx_ready |-> tx_out)
    else $error("tx_out low while tx_ready high");

endmodule

bind uart_loopback uart_loopback_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx_valid (tx_valid),
  .tx_ready (tx_ready),
  .tx_out   (tx_out),
  .rx_frame (rx_frame)
);

// ==== tb/tb_uart_loopback.sv ====
// Testbench top for the UART loopback design; drives random traffic in loopback and external mode
`timescale 1ns/100ps

module tb_uart_loopback;

  localparam int frame_cycles   = 14;
  localparam int timeout_cycles = 80 * frame_cycles + 200;

  logic                           clk;
  logic                           rst_n;
  logic                           rx_in;
  logic [uart_pkg::data_bits-1:0] tx_data;
  logic                           tx_valid;
  logic                           loopback_enable;
  logic                           tx_out;
  logic                           tx_ready;
  uart_pkg::rx_frame_t            rx_frame;
  uart_pkg::check_status_t        status;
  logic                           ext_start;
  logic [uart_pkg::data_bits-1:0] ext_byte;
  logic                           ext_bad;
  int                             sb_errors;
  int                             pending;
  int                             cycles = 0;
  integer                         seed;
  logic [31:0]                    rnd;

  uart_loopback uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .rx_in           (rx_in),
    .tx_data         (tx_data),
    .tx_valid        (tx_valid),
    .loopback_enable (loopback_enable),
    .tx_out          (tx_out),
    .tx_ready        (tx_ready),
    .rx_frame        (rx_frame),
    .status          (status)
  );

  uart_scoreboard u_scoreboard (
    .clk             (clk),
    .rst_n           (rst_n),
    .tx_data         (tx_data),
    .tx_valid        (tx_valid),
    .loopback_enable (loopback_enable),
    .tx_out          (tx_out),
    .tx_ready        (tx_ready),
    .rx_frame        (rx_frame),
    .status          (status),
    .ext_start       (ext_start),
    .ext_byte        (ext_byte),
    .ext_bad         (ext_bad),
    .errors          (sb_errors),
    .pending         (pending)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // A gap of zero keeps tx_valid high through the busy frame
  task automatic send_byte(input logic [uart_pkg::data_bits-1:0] b, input int gap);
    tx_data  <= b;
    tx_valid <= 1'b1;
    do @(posedge clk); while (!tx_ready);
    if (gap > 0) begin
      tx_valid <= 1'b0;
      // Idle cycles count from the end of the frame
      do @(posedge clk); while (!tx_ready);
      repeat (gap - 1) @(posedge clk);
    end
  endtask

  task automatic drive_frame(input logic [uart_pkg::data_bits-1:0] b, input logic bad,
                             input int gap);
    logic [uart_pkg::data_bits-1:0] bits;
    bits = b;
    rx_in     <= 1'b0;
    ext_start <= 1'b1;
    ext_byte  <= b;
    ext_bad   <= bad;
    @(posedge clk);
    ext_start <= 1'b0;
    repeat (uart_pkg::data_bits) begin
      rx_in <= bits[0];
      bits = bits >> 1;
      @(posedge clk);
    end
    rx_in <= !bad;
    @(posedge clk);
    rx_in <= 1'b1;
    repeat (gap + 1) @(posedge clk);
  endtask

  // Both sides quiet before a mode change
  task automatic wait_idle();
    do @(negedge clk); while (pending != 0 || !tx_ready);
    repeat (2) @(posedge clk);
  endtask

  initial begin
    seed            = 34113;
    rst_n           = 1'b0;
    rx_in           = 1'b1;
    tx_data         = '0;
    tx_valid        = 1'b0;
    loopback_enable = 1'b1;
    ext_start       = 1'b0;
    ext_byte        = '0;
    ext_bad         = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      send_byte(rnd[7:0], int'(rnd[9:8]));
    end
    tx_valid <= 1'b0;
    wait_idle();

    loopback_enable <= 1'b0;
    @(posedge clk);
    fork
      begin
        for (int i = 0; i < 30; i++) begin
          rnd = $random(seed);
          drive_frame(rnd[7:0], (rnd[15:8] % 8'd5) == 8'd0, int'(rnd[17:16]) % 3);
        end
      end
      begin
        for (int i = 0; i < 25; i++) begin
          rnd = $random(seed);
          send_byte(rnd[7:0], int'(rnd[9:8]));
        end
        tx_valid <= 1'b0;
      end
    join
    wait_idle();

    loopback_enable <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      rnd = $random(seed);
      send_byte(rnd[7:0], int'(rnd[9:8]));
    end
    tx_valid <= 1'b0;
    wait_idle();

    $display("Error count: %0d check failures, %0d checker errors", sb_errors,
             int'(status.errors));
    if (sb_errors == 0 && status.errors == '0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

// ==== files.f ====
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/loopback_checker.sv
logic/uart_loopback.sv
tb/uart_scoreboard.sv
tb/uart_loopback_props.sv
tb/tb_uart_loopback.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the UART loopback simulation with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_uart_loopback \
  -f files.f \
  -o sim_uart
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/sim_uart 2>&1)"
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$output" | grep -q -F -x "Done: no errors"; then
  exit 0
fi
echo "Pass message not found"
exit 1
